// File: hdl/wino_adder_tree.sv
`default_nettype none

module wino_adder_tree
	import wino_data_pkg::*;
(
	input  wire                      clk,
	input  wire signed [ACC_W-1:0]   i_a0,
	input  wire signed [ACC_W-1:0]   i_a1,
	input  wire signed [ACC_W-1:0]   i_a2,
	input  wire signed [ACC_W-1:0]   i_a3,
	input  wire signed [ACC_W-1:0]   i_a4,
	input  wire signed [ACC_W-1:0]   i_a5,
	output logic signed [ACC_W-1:0]  o_sum
);

	logic signed [ACC_W-1:0] s1_0;
	logic signed [ACC_W-1:0] s1_1;
	logic signed [ACC_W-1:0] s1_2;
	logic signed [ACC_W-1:0] s2_0;
	logic signed [ACC_W-1:0] s2_1;

	// Sums wrap at ACC_W, same as truncating a wider result
	always_ff @(posedge clk) begin
		s1_0 <= i_a0 + i_a1;
		s1_1 <= i_a2 + i_a3;
		s1_2 <= i_a4 + i_a5;
		s2_0 <= s1_0 + s1_1;
		s2_1 <= s1_2;
		o_sum <= s2_0 + s2_1;
	end

endmodule

`default_nettype wire

// File: hdl/wino_at_transform.sv
`default_nettype none

module wino_at_transform
	import wino_data_pkg::*;
(
	input  wire               clk,
	input  wino_row_t         i_vec,
	output wino_col_t         o_col
);

	logic signed [ACC_W-1:0] term [4][6];
	logic signed [ACC_W-1:0] sum [4];

	// ########################################################################
	// A^T rows, scaled and negated terms
	// ########################################################################
	always_comb begin
		term[0] = '{i_vec.e0, i_vec.e1, i_vec.e2, i_vec.e3, i_vec.e4, ACC_W'(0)};
		term[1] = '{ACC_W'(0), i_vec.e1, -i_vec.e2,
			i_vec.e3 <<< 1, -(i_vec.e4 <<< 1), ACC_W'(0)};
		term[2] = '{ACC_W'(0), i_vec.e1, i_vec.e2,
			i_vec.e3 <<< 2, i_vec.e4 <<< 2, ACC_W'(0)};
		term[3] = '{ACC_W'(0), i_vec.e1, -i_vec.e2,
			i_vec.e3 <<< 3, -(i_vec.e4 <<< 3), i_vec.e5};
	end

	for (genvar r = 0; r < 4; r++) begin : g_row
		wino_adder_tree u_tree (
			.clk   (clk),
			.i_a0  (term[r][0]),
			.i_a1  (term[r][1]),
			.i_a2  (term[r][2]),
			.i_a3  (term[r][3]),
			.i_a4  (term[r][4]),
			.i_a5  (term[r][5]),
			.o_sum (sum[r])
		);
	end

	assign o_col.y0 = sum[0];
	assign o_col.y1 = sum[1];
	assign o_col.y2 = sum[2];
	assign o_col.y3 = sum[3];

endmodule

`default_nettype wire

// File: hdl/wino_beat_counter.sv
`default_nettype none

module wino_beat_counter
	import wino_ctrl_pkg::*;
(
	input  wire   clk,
	input  wire   i_rst_n,
	input  wire   i_capture,
	input  wire   i_drain,
	output logic  o_fill_last,
	output logic  o_drain_last
);

	logic [FILL_CNT_W-1:0]  fill_cnt;
	logic [DRAIN_CNT_W-1:0] drain_cnt;

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			fill_cnt <= '0;
			drain_cnt <= '0;
		end else begin
			if (i_capture) begin
				if (o_fill_last) begin
					fill_cnt <= '0;
				end else begin
					fill_cnt <= fill_cnt + 1'b1;
				end
			end
			// Two bits wrap after the fourth column on their own
			if (i_drain) begin
				drain_cnt <= drain_cnt + 1'b1;
			end
		end
	end

	assign o_fill_last = (fill_cnt == FILL_CNT_W'(5));
	assign o_drain_last = (drain_cnt == DRAIN_CNT_W'(3));

endmodule

`default_nettype wire

// File: hdl/wino_ctrl_pkg.sv
`default_nettype none

package wino_ctrl_pkg;

	// Drain sequencing
	typedef enum logic [1:0] {
		S_IDLE,
		S_DRAIN,
		S_DRAIN_FILL
	} wino_state_e;

	// Six rows per tile, four columns per drain
	localparam int FILL_CNT_W = 3;
	localparam int DRAIN_CNT_W = 2;

	// Register stages of one adder tree
	localparam int AT_LATENCY = 3;

endpackage

`default_nettype wire

// File: hdl/wino_data_pkg.sv
`default_nettype none

package wino_data_pkg;

	localparam int ACC_W = 30;
	localparam int OUT_W = 16;

	// One tile row at the input, or one drain vector into the row pass
	typedef struct packed {
		logic signed [ACC_W-1:0] e0;
		logic signed [ACC_W-1:0] e1;
		logic signed [ACC_W-1:0] e2;
		logic signed [ACC_W-1:0] e3;
		logic signed [ACC_W-1:0] e4;
		logic signed [ACC_W-1:0] e5;
	} wino_row_t;

	// Four A^T outputs of one pass
	typedef struct packed {
		logic signed [ACC_W-1:0] y0;
		logic signed [ACC_W-1:0] y1;
		logic signed [ACC_W-1:0] y2;
		logic signed [ACC_W-1:0] y3;
	} wino_col_t;

	typedef struct packed {
		logic [OUT_W-1:0] y0;
		logic [OUT_W-1:0] y1;
		logic [OUT_W-1:0] y2;
		logic [OUT_W-1:0] y3;
	} wino_out_t;

endpackage

`default_nettype wire

// File: hdl/wino_inverse_transform.sv
`default_nettype none

module wino_inverse_transform
	import wino_data_pkg::*;
	import wino_ctrl_pkg::*;
#(
	parameter int FRAC_BITS = 8
) (
	input  wire        clk,
	input  wire        i_rst_n,
	input  wire        i_valid,
	input  wino_row_t  i_row,
	output logic       o_valid,
	output wino_out_t  o_result
);

	logic [AT_LATENCY-1:0] vld_q;
	logic                  capture;
	wino_col_t             col;
	logic                  fill_last;
	logic                  drain_last;
	logic                  load;
	logic                  drain;
	wino_row_t             drain_vec;

	// ########################################################################
	// Column pass and capture alignment
	// ########################################################################
	wino_at_transform u_col_at (
		.clk   (clk),
		.i_vec (i_row),
		.o_col (col)
	);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[AT_LATENCY-2:0], i_valid};
		end
	end

	assign capture = vld_q[AT_LATENCY-1];

	// ########################################################################
	// Gather, corner turn and drain control
	// ########################################################################
	wino_tile_buffer u_buf (
		.clk       (clk),
		.i_capture (capture),
		.i_col     (col),
		.i_load    (load),
		.i_drain   (drain),
		.o_vec     (drain_vec)
	);

	wino_beat_counter u_cnt (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_capture    (capture),
		.i_drain      (drain),
		.o_fill_last  (fill_last),
		.o_drain_last (drain_last)
	);

	wino_seq_fsm u_fsm (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_capture    (capture),
		.i_fill_last  (fill_last),
		.i_drain_last (drain_last),
		.o_load       (load),
		.o_drain      (drain)
	);

	wino_output_stage #(
		.FRAC_BITS (FRAC_BITS)
	) u_out (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_vec    (drain_vec),
		.i_drain  (drain),
		.o_valid  (o_valid),
		.o_result (o_result)
	);

endmodule

`default_nettype wire

// File: hdl/wino_output_stage.sv
`default_nettype none

module wino_output_stage
	import wino_data_pkg::*;
	import wino_ctrl_pkg::*;
#(
	parameter int FRAC_BITS = 8
) (
	input  wire        clk,
	input  wire        i_rst_n,
	input  wino_row_t  i_vec,
	input  wire        i_drain,
	output logic       o_valid,
	output wino_out_t  o_result
);

	wino_col_t             col;
	logic [AT_LATENCY-1:0] vld_q;

	// Negative clamps to zero, else take the integer field above the fraction
	function automatic logic [OUT_W-1:0] rectify(logic signed [ACC_W-1:0] v);
		return v[ACC_W-1] ? '0 : v[FRAC_BITS +: OUT_W];
	endfunction

	wino_at_transform u_row_at (
		.clk   (clk),
		.i_vec (i_vec),
		.o_col (col)
	);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			vld_q <= '0;
			o_valid <= 1'b0;
		end else begin
			vld_q <= {vld_q[AT_LATENCY-2:0], i_drain};
			o_valid <= vld_q[AT_LATENCY-1];
		end
	end

	always_ff @(posedge clk) begin
		if (vld_q[AT_LATENCY-1]) begin
			o_result.y0 <= rectify(col.y0);
			o_result.y1 <= rectify(col.y1);
			o_result.y2 <= rectify(col.y2);
			o_result.y3 <= rectify(col.y3);
		end
	end

endmodule

`default_nettype wire

// File: hdl/wino_seq_fsm.sv
`default_nettype none

module wino_seq_fsm
	import wino_ctrl_pkg::*;
(
	input  wire   clk,
	input  wire   i_rst_n,
	input  wire   i_capture,
	input  wire   i_fill_last,
	input  wire   i_drain_last,
	output logic  o_load,
	output logic  o_drain
);

	wino_state_e state;
	wino_state_e state_nxt;

	// Sixth row of a tile is being captured
	assign o_load = i_capture & i_fill_last;

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (o_load) begin
					state_nxt = S_DRAIN;
				end
			end
			S_DRAIN, S_DRAIN_FILL: begin
				if (i_drain_last) begin
					state_nxt = o_load ? S_DRAIN : S_IDLE;
				end else if (o_load) begin
					state_nxt = S_DRAIN;
				end else if (i_capture) begin
					state_nxt = S_DRAIN_FILL;
				end
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	assign o_drain = (state == S_DRAIN) || (state == S_DRAIN_FILL);

endmodule

`default_nettype wire

// File: hdl/wino_tile_buffer.sv
`default_nettype none

module wino_tile_buffer
	import wino_data_pkg::*;
(
	input  wire        clk,
	input  wire        i_capture,
	input  wino_col_t  i_col,
	input  wire        i_load,
	input  wire        i_drain,
	output wino_row_t  o_vec
);

	// Newest row in slot 0; the sixth row is taken from i_col on load
	wino_col_t fill_q [5];
	wino_col_t rows [6];
	wino_row_t load_vec [4];
	wino_row_t drain_q [4];

	function automatic logic signed [ACC_W-1:0] pick(wino_col_t c, int unsigned j);
		case (j)
			0: return c.y0;
			1: return c.y1;
			2: return c.y2;
			default: return c.y3;
		endcase
	endfunction

	assign rows = '{fill_q[4], fill_q[3], fill_q[2], fill_q[1], fill_q[0], i_col};

	// Corner turn, vector j holds column j of every row
	always_comb begin
		for (int j = 0; j < 4; j++) begin
			load_vec[j].e0 = pick(rows[0], j);
			load_vec[j].e1 = pick(rows[1], j);
			load_vec[j].e2 = pick(rows[2], j);
			load_vec[j].e3 = pick(rows[3], j);
			load_vec[j].e4 = pick(rows[4], j);
			load_vec[j].e5 = pick(rows[5], j);
		end
	end

	always_ff @(posedge clk) begin
		if (i_capture) begin
			fill_q[0] <= i_col;
			for (int k = 1; k < 5; k++) begin
				fill_q[k] <= fill_q[k-1];
			end
		end
		if (i_load) begin
			drain_q <= load_vec;
		end else if (i_drain) begin
			drain_q[0] <= drain_q[1];
			drain_q[1] <= drain_q[2];
			drain_q[2] <= drain_q[3];
		end
	end

	assign o_vec = drain_q[0];

endmodule

`default_nettype wire

// File: verification/wino_inverse_properties.sv
`default_nettype none

module wino_inverse_properties
	import wino_data_pkg::*;
(
	input wire            clk,
	input wire            i_rst_n,
	input wire            o_valid,
	input wire wino_out_t o_result
);

	int fail_cnt = 0;

	// No tile can come out within one latency of reset release
	a_idle_after_reset: assert property (@(posedge clk) $rose(i_rst_n) |-> !o_valid [*12])
		else begin
			fail_cnt++;
			$error("o_valid went high within 12 cycles of reset release");
		end

	// One drain gives exactly four output beats
	a_run_of_four: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(o_valid) |-> o_valid [*4] ##1 !o_valid)
		else begin
			fail_cnt++;
			$error("o_valid run is not four cycles followed by a low cycle");
		end

	a_result_known: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_valid |-> !$isunknown(o_result))
		else begin
			fail_cnt++;
			$error("o_result has unknown bits while o_valid is high");
		end

endmodule

bind wino_inverse_transform wino_inverse_properties u_props (
	.clk      (clk),
	.i_rst_n  (i_rst_n),
	.o_valid  (o_valid),
	.o_result (o_result)
);

`default_nettype wire

// File: verification/wino_inverse_tb.sv
`default_nettype none

module wino_inverse_tb
	import wino_data_pkg::*;
();

	localparam int FRAC_BITS = 8;
	localparam logic [15:0] SEED = 16'd20;
	localparam int TILE_COUNT = 12;
	localparam int TIMEOUT_CYCLES = TILE_COUNT * 16 + 200;
	localparam int LATENCY = 12;

	// F(4,3) inverse transform matrix A^T
	localparam int AT [4][6] = '{
		'{1, 1, 1, 1, 1, 0},
		'{0, 1, -1, 2, -2, 0},
		'{0, 1, 1, 4, 4, 0},
		'{0, 1, -1, 8, -8, 1}
	};

	logic      clk;
	logic      i_rst_n;
	logic      i_valid;
	wino_row_t i_row;
	logic      o_valid;
	wino_out_t o_result;

	logic [15:0] lfsr;
	int          err_cnt;
	int          chk_cnt;
	int          test_cnt;
	int          tiles_made;
	int          neg_fields;
	int          neg_cnt;

	wino_row_t tile_q [$];
	wino_out_t exp_q [$];
	wino_out_t out_q [$];
	int        out_edge_q [$];
	int        in_edge_q [$];

	wino_inverse_transform #(
		.FRAC_BITS (FRAC_BITS)
	) dut (
		.clk      (clk),
		.i_rst_n  (i_rst_n),
		.i_valid  (i_valid),
		.i_row    (i_row),
		.o_valid  (o_valid),
		.o_result (o_result)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Inputs are tagged with the edge that samples them, outputs with the edge that made them
	always @(negedge clk) begin
		if (i_rst_n === 1'b1) begin
			if (i_valid) begin
				in_edge_q.push_back(neg_cnt + 1);
			end
			if (o_valid) begin
				out_q.push_back(o_result);
				out_edge_q.push_back(neg_cnt);
			end
		end
		neg_cnt <= neg_cnt + 1;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

	// ########################################################################
	// Stimulus and reference model
	// ########################################################################
	function automatic logic [15:0] galois_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = galois_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic longint elem(input wino_row_t r, input int c);
		case (c)
			0: return longint'(r.e0);
			1: return longint'(r.e1);
			2: return longint'(r.e2);
			3: return longint'(r.e3);
			4: return longint'(r.e4);
			default: return longint'(r.e5);
		endcase
	endfunction

	// Kind 0 is unsigned 10-bit, kind 1 is signed 12-bit scaled by 16
	task automatic make_tile(input int kind);
		wino_row_t               row;
		logic [31:0]             bits;
		logic signed [ACC_W-1:0] v [6];
		for (int r = 0; r < 6; r++) begin
			for (int c = 0; c < 6; c++) begin
				if (kind == 0) begin
					draw_bits(10, bits);
					v[c] = ACC_W'(bits);
				end else begin
					draw_bits(12, bits);
					v[c] = ACC_W'((int'(bits) - 2048) * 16);
				end
			end
			row.e0 = v[0];
			row.e1 = v[1];
			row.e2 = v[2];
			row.e3 = v[3];
			row.e4 = v[4];
			row.e5 = v[5];
			tile_q.push_back(row);
		end
		tiles_made++;
	endtask

	task automatic make_impulse_tile();
		wino_row_t row;
		for (int r = 0; r < 6; r++) begin
			row = '0;
			if (r == 0) begin
				row.e0 = ACC_W'(1) <<< FRAC_BITS;
			end
			tile_q.push_back(row);
		end
		tiles_made++;
	endtask

	// Y = A^T M A at full width, wrapped to ACC_W, then rectified
	task automatic model_tile(input int tile);
		longint                  y;
		logic signed [ACC_W-1:0] t;
		logic [OUT_W-1:0]        f [4];
		wino_out_t               beat;
		for (int j = 0; j < 4; j++) begin
			for (int i = 0; i < 4; i++) begin
				y = 0;
				for (int r = 0; r < 6; r++) begin
					for (int c = 0; c < 6; c++) begin
						y += AT[i][r] * elem(tile_q[6 * tile + r], c) * AT[j][c];
					end
				end
				t = y[ACC_W-1:0];
				if (t < 0) begin
					neg_fields++;
					f[i] = '0;
				end else begin
					f[i] = t[FRAC_BITS +: OUT_W];
				end
			end
			beat.y0 = f[0];
			beat.y1 = f[1];
			beat.y2 = f[2];
			beat.y3 = f[3];
			exp_q.push_back(beat);
		end
	endtask

	// ########################################################################
	// Checks
	// ########################################################################
	task automatic check_out(input string name, input int beat, input wino_out_t exp,
		input wino_out_t act);
		chk_cnt++;
		if (act !== exp) begin
			err_cnt++;
			$display("Mismatch %s beat %0d: expected %h, actual %h", name, beat, exp, act);
		end
	endtask

	task automatic check_valid_run(input string name, input int tile, input int first_edge,
		input int idx);
		logic bad;
		bad = 1'b0;
		chk_cnt++;
		for (int b = 0; b < 4; b++) begin
			if (idx + b >= out_edge_q.size()) begin
				bad = 1'b1;
			end else if (out_edge_q[idx + b] != first_edge + LATENCY + b) begin
				bad = 1'b1;
			end
		end
		if (idx + 4 < out_edge_q.size() && out_edge_q[idx + 4] == first_edge + LATENCY + 4) begin
			bad = 1'b1;
		end
		if (bad) begin
			err_cnt++;
			$display("%s: tile %0d did not give four o_valid cycles starting %0d cycles after %s",
				name, tile, LATENCY, "its first beat");
		end
	endtask

	task automatic run_tiles(input string name, input int first, input int n, input int gap);
		int waited;
		out_q.delete();
		out_edge_q.delete();
		in_edge_q.delete();
		exp_q.delete();
		for (int t = 0; t < n; t++) begin
			model_tile(first + t);
		end
		for (int t = 0; t < n; t++) begin
			for (int r = 0; r < 6; r++) begin
				@(posedge clk);
				i_valid <= 1'b1;
				i_row <= tile_q[6 * (first + t) + r];
			end
			repeat (gap) begin
				@(posedge clk);
				i_valid <= 1'b0;
				i_row <= '0;
			end
		end
		@(posedge clk);
		i_valid <= 1'b0;
		i_row <= '0;
		waited = 0;
		while (out_q.size() < 4 * n && waited < 20 * n + 20) begin
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk);
		chk_cnt++;
		if (out_q.size() != 4 * n) begin
			err_cnt++;
			$display("%s: expected %0d output beats but got %0d", name, 4 * n, out_q.size());
		end
		for (int b = 0; b < 4 * n && b < out_q.size(); b++) begin
			check_out(name, b, exp_q[b], out_q[b]);
		end
		for (int t = 0; t < n && 6 * t < in_edge_q.size(); t++) begin
			check_valid_run(name, t, in_edge_q[6 * t], 4 * t);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("Test %-16s passed", name);
		end else begin
			$display("Test %-16s failed, %0d bad checks", name, err_cnt - errs_before);
		end
	endtask

	// ########################################################################
	// Tests
	// ########################################################################
	task automatic test_reset_impulse();
		int        errs;
		wino_out_t exp;
		errs = err_cnt;
		repeat (4) @(posedge clk);
		@(negedge clk);
		chk_cnt++;
		if (o_valid !== 1'b0 || out_q.size() != 0) begin
			err_cnt++;
			$display("reset_impulse: o_valid went high after reset with no input");
		end
		make_impulse_tile();
		run_tiles("reset_impulse", tiles_made - 1, 1, 0);
		for (int b = 0; b < 4 && b < out_q.size(); b++) begin
			exp = '0;
			if (b == 0) begin
				exp.y0 = OUT_W'(1);
			end
			check_out("reset_impulse", b, exp, out_q[b]);
		end
		report_test("reset_impulse", errs);
	endtask

	task automatic test_latency();
		int errs;
		errs = err_cnt;
		repeat (3) @(posedge clk);
		make_tile(0);
		run_tiles("latency", tiles_made - 1, 1, 0);
		report_test("latency", errs);
	endtask

	task automatic test_random_positive();
		int errs;
		int first;
		errs = err_cnt;
		first = tiles_made;
		for (int t = 0; t < 4; t++) begin
			make_tile(0);
		end
		run_tiles("random_positive", first, 4, 1);
		report_test("random_positive", errs);
	endtask

	task automatic test_rectification();
		int errs;
		int first;
		int neg_before;
		errs = err_cnt;
		first = tiles_made;
		neg_before = neg_fields;
		for (int t = 0; t < 3; t++) begin
			make_tile(1);
		end
		run_tiles("rectification", first, 3, 2);
		chk_cnt++;
		if (neg_fields == neg_before) begin
			err_cnt++;
			$display("rectification: the tiles produced no negative result to clamp");
		end
		report_test("rectification", errs);
	endtask

	task automatic test_back_to_back();
		int errs;
		int first;
		errs = err_cnt;
		first = tiles_made;
		for (int t = 0; t < 3; t++) begin
			make_tile(0);
		end
		run_tiles("back_to_back", first, 3, 0);
		for (int t = 0; t < 2 && 4 * t + 4 < out_edge_q.size(); t++) begin
			chk_cnt++;
			if (out_edge_q[4 * t + 4] - out_edge_q[4 * t + 3] != 3) begin
				err_cnt++;
				$display("back_to_back: runs %0d and %0d are not two low cycles apart", t, t + 1);
			end
		end
		report_test("back_to_back", errs);
	endtask

	initial begin
		lfsr = SEED;
		err_cnt = 0;
		chk_cnt = 0;
		test_cnt = 0;
		tiles_made = 0;
		neg_fields = 0;
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		i_row = '0;
		repeat (2) @(posedge clk);
		i_rst_n <= 1'b1;

		test_reset_impulse();
		test_latency();
		test_random_positive();
		test_rectification();
		test_back_to_back();

		if (dut.u_props.fail_cnt != 0) begin
			$display("Bound assertions failed %0d times", dut.u_props.fail_cnt);
			err_cnt += dut.u_props.fail_cnt;
		end
		$display("Tests: %0d, checks: %0d, failures: %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: wino_inverse.f
hdl/wino_data_pkg.sv
hdl/wino_ctrl_pkg.sv
hdl/wino_adder_tree.sv
hdl/wino_at_transform.sv
hdl/wino_tile_buffer.sv
hdl/wino_beat_counter.sv
hdl/wino_seq_fsm.sv
hdl/wino_output_stage.sv
hdl/wino_inverse_transform.sv
verification/wino_inverse_properties.sv
verification/wino_inverse_tb.sv
